//--- Makefile
# Verilator flow for the serial receive project

TB = uartRxTopTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module uartRxTop -f uartRxTop.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB) \
		-f uartRxTop.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bistEngine.sv
// Loopback BIST engine
// Sends an LFSR sequence into the receiver and checks each returned character
`include "uartRx_cfg.svh"

module bistEngine import uartPkg::*; (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic bistMode,
        input  logic rxLine,
        output logic lineSel,
        rxByteIf.bistMon rxMon,
        output logic bistBusy,
        output logic bistDone,
        output logic bistPass
);
        localparam int CntW = $clog2(`CLKS_PER_BIT);
        localparam int IdxW = $clog2(`DATA_BITS);
        localparam int NumW = $clog2(`BIST_BYTES + 1);

        logic bistModeD;                 // Edge detect
        logic [`DATA_BITS-1:0] lfsr;     // 8-bit, taps 8 6 5 4
        rxState_t txState;
        logic [CntW-1:0] txCnt;
        logic [IdxW-1:0] txBit;
        logic txLine;
        logic waitRx;                    // Frame out, strobe not back yet
        logic [NumW-1:0] charCnt;
        logic failed;
        logic match;
        logic lastChar;
        logic bitDone;

        assign lineSel = bistMode ? txLine : rxLine;
        assign match = (rxMon.data == lfsr) && (rxMon.status == '0);
        assign lastChar = (charCnt == NumW'(`BIST_BYTES - 1));
        assign bitDone = (txCnt == CntW'(`CLKS_PER_BIT - 1));

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        bistModeD <= 1'b0;
                        lfsr <= `BIST_SEED;
                        txState <= rxIdle;
                        txCnt <= '0;
                        txBit <= '0;
                        txLine <= 1'b1;
                        waitRx <= 1'b0;
                        charCnt <= '0;
                        failed <= 1'b0;
                        bistBusy <= 1'b0;
                        bistDone <= 1'b0;
                        bistPass <= 1'b0;
                end else begin
                        bistModeD <= bistMode;
                        if (!bistMode) begin     // Abort, or release a finished run
                                txState <= rxIdle;
                                txLine <= 1'b1;
                                waitRx <= 1'b0;
                                bistBusy <= 1'b0;
                                bistDone <= 1'b0;
                                bistPass <= 1'b0;
                        end else if (!bistModeD) begin
                                lfsr <= `BIST_SEED;   // New run
                                charCnt <= '0;
                                failed <= 1'b0;
                                bistBusy <= 1'b1;
                        end else if (bistBusy) begin
                                ////////////////////
                                // Serializer
                                txCnt <= bitDone ? '0 : txCnt + 1'b1;
                                case (txState)
                                rxIdle: begin
                                        txCnt <= '0;
                                        if (!waitRx && !rxMon.busy) begin
                                                txState <= rxStart;
                                                txLine <= 1'b0;       // Start bit
                                                waitRx <= 1'b1;
                                        end
                                end
                                rxStart: if (bitDone) begin
                                        txState <= rxData;
                                        txBit <= '0;
                                        txLine <= lfsr[0];
                                end
                                rxData: if (bitDone) begin
                                        txBit <= txBit + 1'b1;
                                        if (txBit != IdxW'(`DATA_BITS - 1)) begin
                                                txLine <= lfsr[txBit + 1'b1];
                                        end else if (`PARITY_EN != 0) begin
                                                txState <= rxParity;
                                                txLine <= ^lfsr;      // Even parity
                                        end else begin
                                                txState <= rxStop;
                                                txLine <= 1'b1;
                                        end
                                end
                                rxParity: if (bitDone) begin
                                        txState <= rxStop;
                                        txLine <= 1'b1;
                                end
                                default: if (bitDone)
                                        txState <= rxIdle;
                                endcase

                                // Compare what came back
                                if (rxMon.strobe && waitRx) begin
                                        waitRx <= 1'b0;
                                        lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                                        charCnt <= charCnt + 1'b1;
                                        failed <= failed | !match;
                                        if (lastChar) begin
                                                bistBusy <= 1'b0;
                                                bistDone <= 1'b1;
                                                bistPass <= !failed && match;
                                        end
                                end
                        end
                end
        end

        busyDoneExcl: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                !(bistBusy && bistDone));

endmodule

//--- fifoPkg.sv
// Buffer-side types of the receive FIFO
// Stored word and occupancy count
`include "uartRx_cfg.svh"

package fifoPkg;
        import uartPkg::*;

        // One stored character, status on top
        typedef struct packed {
                rxStatus_t status;
                logic [`DATA_BITS-1:0] data;
        } fifoEntry_t;

        typedef logic [`FIFO_WIDTH:0] fifoCount_t;  // 0 up to full depth

endpackage

//--- rxByteIf.sv
// Received character bus
// Carries each character and its status from the deserializer to its listeners
`include "uartRx_cfg.svh"

interface rxByteIf import uartPkg::*; ();
        logic [`DATA_BITS-1:0] data;
        rxStatus_t status;
        logic strobe;   // One cycle per character
        logic busy;     // Frame in progress

        modport rxSrc (output data, status, strobe, busy);
        modport fifoSink (input data, status, strobe);   // Push side of the FIFO
        modport bistMon (input data, status, strobe, busy);
endinterface

//--- rxFifo.sv
// Receive FIFO
// Buffers characters with status, reports occupancy, holds still in BIST mode
`include "uartRx_cfg.svh"

module rxFifo import uartPkg::*, fifoPkg::*; (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic bistMode,
        rxByteIf.fifoSink rxIn,
        input  logic popReq,
        output logic [`DATA_BITS-1:0] dataOut,
        output rxStatus_t dataStatus,
        output logic fifoEmpty,
        output logic fifoHalf,
        output logic fifoFull,
        output logic fifoOverflow
);
        localparam int Depth = 2 ** `FIFO_WIDTH;

        fifoEntry_t mem [Depth];
        logic [`FIFO_WIDTH-1:0] wrPtr;
        logic [`FIFO_WIDTH-1:0] rdPtr;
        fifoCount_t count;
        fifoCount_t countNext;
        logic pushOk;      // Character stored
        logic pushDrop;    // Character lost, FIFO full
        logic popOk;

        assign pushOk = !bistMode && rxIn.strobe && !fifoFull;
        assign pushDrop = !bistMode && rxIn.strobe && fifoFull;
        assign popOk = !bistMode && popReq && !fifoEmpty;   // Empty pop ignored
        assign countNext = count + fifoCount_t'(pushOk) - fifoCount_t'(popOk);

        // Storage
        always_ff @(posedge Data_Rdy) begin
                if (pushOk)
                        mem[wrPtr] <= '{status: rxIn.status, data: rxIn.data};
        end

        ////////////////////
        // Pointers, flags, output word
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                        fifoEmpty <= 1'b1;
                        fifoHalf <= 1'b0;
                        fifoFull <= 1'b0;
                        fifoOverflow <= 1'b0;
                        dataOut <= '0;
                        dataStatus <= '0;
                end else begin
                        if (pushOk)
                                wrPtr <= wrPtr + 1'b1;   // Wraps around the array
                        if (popOk) begin
                                rdPtr <= rdPtr + 1'b1;
                                dataOut <= mem[rdPtr].data;
                                dataStatus <= mem[rdPtr].status;
                        end
                        count <= countNext;              // Push and pop together cancel
                        fifoEmpty <= (countNext == '0);
                        fifoHalf <= (countNext >= fifoCount_t'(Depth / 2));
                        fifoFull <= (countNext == fifoCount_t'(Depth));
                        if (pushDrop)
                                fifoOverflow <= 1'b1;    // Sticky until a pop
                        else if (popOk)
                                fifoOverflow <= 1'b0;
                end
        end

        ////////////////////
        // Checks
        flagsExcl: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                !(fifoEmpty && fifoFull));
        countBound: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                count <= fifoCount_t'(Depth));

endmodule

//--- uartPkg.sv
// Line-side types of the serial receiver
// Frame state and per-character status
package uartPkg;

        // Frame position, shared by receiver and BIST serializer
        typedef enum logic [2:0] {
                rxIdle   = 3'd0,
                rxStart  = 3'd1,
                rxData   = 3'd2,
                rxParity = 3'd3,
                rxStop   = 3'd4
        } rxState_t;

        typedef struct packed {
                logic frameErr;    // Stop bit read low
                logic parityErr;   // Even parity mismatch
        } rxStatus_t;

endpackage

//--- uartRx.sv
// Serial deserializer
// Synchronizes the line, samples mid-bit, checks parity and stop bit
`include "uartRx_cfg.svh"

module uartRx import uartPkg::*; (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic line,
        rxByteIf.rxSrc rxOut
);
        localparam int CntW = $clog2(`CLKS_PER_BIT);
        localparam int IdxW = $clog2(`DATA_BITS);

        logic [1:0] syncFf;              // Two-flop synchronizer
        logic lineS;                     // Synchronized line
        rxState_t state;
        logic [CntW-1:0] clkCnt;         // Cycles into the current bit
        logic [IdxW-1:0] bitIdx;
        logic [`DATA_BITS-1:0] shiftReg;
        logic parityBad;
        logic midStart;                  // Half-bit point of the start bit
        logic bitMid;                    // Middle of a data, parity or stop bit

        assign lineS = syncFf[1];
        assign midStart = (clkCnt == CntW'(`CLKS_PER_BIT / 2 - 1));
        assign bitMid = (clkCnt == CntW'(`CLKS_PER_BIT - 1));
        assign rxOut.busy = (state != rxIdle);
        assign rxOut.data = shiftReg;    // Stable from last data bit to next frame

        ////////////////////
        // Frame FSM
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        syncFf <= 2'b11;          // Line idles high
                        state <= rxIdle;
                        clkCnt <= '0;
                        bitIdx <= '0;
                        parityBad <= 1'b0;
                        rxOut.strobe <= 1'b0;
                        rxOut.status <= '0;
                end else begin
                        syncFf <= {syncFf[0], line};
                        rxOut.strobe <= 1'b0;     // Pulse only
                        clkCnt <= clkCnt + 1'b1;
                        case (state)
                        rxIdle: begin
                                clkCnt <= '0;
                                if (!lineS)
                                        state <= rxStart;   // Falling edge seen
                        end
                        rxStart: if (midStart) begin
                                clkCnt <= '0;
                                bitIdx <= '0;
                                parityBad <= 1'b0;
                                state <= lineS ? rxIdle : rxData;  // High again means a glitch
                        end
                        rxData: if (bitMid) begin
                                clkCnt <= '0;
                                bitIdx <= bitIdx + 1'b1;
                                if (bitIdx == IdxW'(`DATA_BITS - 1))
                                        state <= (`PARITY_EN != 0) ? rxParity : rxStop;
                        end
                        rxParity: if (bitMid) begin
                                clkCnt <= '0;
                                parityBad <= ^shiftReg ^ lineS;   // Even parity over data
                                state <= rxStop;
                        end
                        default: if (bitMid) begin          // Stop bit
                                state <= rxIdle;
                                rxOut.strobe <= 1'b1;
                                rxOut.status <= '{frameErr: !lineS, parityErr: parityBad};
                        end
                        endcase
                end
        end

        // Data shifter, LSB arrives first
        always_ff @(posedge Data_Rdy) begin
                if (state == rxData && bitMid)
                        shiftReg <= {lineS, shiftReg[`DATA_BITS-1:1]};
        end

        ////////////////////
        // Checks
        strobePulse: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                rxOut.strobe |=> !rxOut.strobe);
        strobeIdle: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                rxOut.strobe |-> !rxOut.busy);

endmodule

//--- uartRxChecker.sv
// Scoreboard for the serial receive top level
// Models the FIFO from sent characters and compares outputs every cycle
`include "uartRx_cfg.svh"

module uartRxChecker import uartPkg::*, fifoPkg::*; (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic bistMode,
        input  logic popReq,
        input  logic strobe,             // Character bus pulse inside the DUT
        input  logic [`DATA_BITS-1:0] dataOut,
        input  rxStatus_t dataStatus,
        input  logic fifoEmpty,
        input  logic fifoHalf,
        input  logic fifoFull,
        input  logic fifoOverflow
);
        timeunit 1ns;
        timeprecision 100ps;

        localparam int Depth = 2 ** `FIFO_WIDTH;

        fifoEntry_t sentQ[$];            // On the line, not yet received
        fifoEntry_t modelQ[$];           // Expected FIFO contents
        fifoCount_t modelCount;
        fifoEntry_t modelOut;            // Expected output word
        logic modelOvf;
        int errCount = 0;
        int timeoutCount = 0;
        int popCount = 0;

        function automatic int pending();
                return sentQ.size();
        endfunction

        function automatic void noteSent(fifoEntry_t e);
                sentQ.push_back(e);
        endfunction

        function automatic void noteTimeout(string what);
                timeoutCount++;
                $display("Timeout while waiting for %s", what);
        endfunction

        function automatic void compareHex(string name, logic [31:0] got, logic [31:0] exp);
                if (got !== exp) begin
                        errCount++;
                        $display("Fail %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
                end
        endfunction

        function automatic void report();
                $display("Checker: %0d errors, %0d timeouts, %0d pops accepted",
                         errCount, timeoutCount, popCount);
        endfunction

        ////////////////////
        // FIFO model, sampled on the same edge as the DUT
        always @(posedge Data_Rdy or posedge Pop_Data) begin : modelUpdate
                fifoEntry_t e;
                int sizeBefore;
                sizeBefore = modelQ.size();
                if (Pop_Data) begin
                        modelQ.delete();
                        modelOut = '0;
                        modelOvf = 1'b0;
                end else if (!bistMode) begin     // BIST freezes everything
                        if (popReq && sizeBefore > 0) begin
                                modelOut = modelQ.pop_front();
                                modelOvf = 1'b0;
                                popCount++;
                        end
                        if (strobe) begin
                                if (sentQ.size() == 0) begin
                                        errCount++;
                                        $display("A character arrived that was never sent");
                                end else begin
                                        e = sentQ.pop_front();
                                        if (sizeBefore < Depth)
                                                modelQ.push_back(e);
                                        else
                                                modelOvf = 1'b1;   // Lost, sticky flag
                                end
                        end
                end
                modelCount = fifoCount_t'(modelQ.size());
        end

        // Outputs are stable halfway through the cycle
        always @(negedge Data_Rdy) begin
                if (!Pop_Data) begin
                        compareHex("dataOut", 32'(dataOut), 32'(modelOut.data));
                        compareHex("dataStatus", 32'(dataStatus), 32'(modelOut.status));
                        compareHex("fifoEmpty", 32'(fifoEmpty), 32'(modelCount == 0));
                        compareHex("fifoHalf", 32'(fifoHalf), 32'(modelCount >= Depth / 2));
                        compareHex("fifoFull", 32'(fifoFull), 32'(modelCount == Depth));
                        compareHex("fifoOverflow", 32'(fifoOverflow), 32'(modelOvf));
                end
        end

endmodule

//--- uartRxTop.f
+incdir+.
uartPkg.sv
fifoPkg.sv
rxByteIf.sv
uartRx.sv
rxFifo.sv
bistEngine.sv
uartRxTop.sv
uartRxChecker.sv
uartRxTopTb.sv

//--- uartRxTop.sv
// Serial receive top level
// Deserializer, receive FIFO and loopback BIST joined on one character bus
`include "uartRx_cfg.svh"

module uartRxTop import uartPkg::*; (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic rxLine,
        input  logic popReq,
        input  logic bistMode,
        output logic [`DATA_BITS-1:0] dataOut,
        output rxStatus_t dataStatus,
        output logic fifoEmpty,
        output logic fifoHalf,
        output logic fifoFull,
        output logic fifoOverflow,
        output logic bistBusy,
        output logic bistDone,
        output logic bistPass
);
        logic lineSel;          // External line or BIST loopback
        rxByteIf byteBus ();

        uartRx uRx (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .line     (lineSel),
                .rxOut    (byteBus.rxSrc)
        );

        rxFifo uFifo (
                .Data_Rdy     (Data_Rdy),
                .Pop_Data     (Pop_Data),
                .bistMode     (bistMode),
                .rxIn         (byteBus.fifoSink),
                .popReq       (popReq),
                .dataOut      (dataOut),
                .dataStatus   (dataStatus),
                .fifoEmpty    (fifoEmpty),
                .fifoHalf     (fifoHalf),
                .fifoFull     (fifoFull),
                .fifoOverflow (fifoOverflow)
        );

        bistEngine uBist (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .bistMode (bistMode),
                .rxLine   (rxLine),
                .lineSel  (lineSel),
                .rxMon    (byteBus.bistMon),
                .bistBusy (bistBusy),
                .bistDone (bistDone),
                .bistPass (bistPass)
        );

endmodule

//--- uartRxTopTb.sv
// Testbench for the serial receive top level
// Serial frames from a table, pops, and loopback BIST runs
`include "uartRx_cfg.svh"

module uartRxTopTb import uartPkg::*, fifoPkg::*; ();
        timeunit 1ns;
        timeprecision 100ps;

        typedef struct {
                logic [7:0] data;
                bit badPar;      // Flip the parity bit
                bit badStop;     // Stop bit low
                int pops;        // Pops after the character
        } stimRow_t;

        localparam int NumRows = 22;

        logic Data_Rdy = 1'b0;
        logic Pop_Data = 1'b1;
        logic rxLine = 1'b1;             // Idle high
        logic popReq = 1'b0;
        logic bistMode = 1'b0;
        logic [`DATA_BITS-1:0] dataOut;
        rxStatus_t dataStatus;
        logic fifoEmpty, fifoHalf, fifoFull, fifoOverflow;
        logic bistBusy, bistDone, bistPass;
        stimRow_t stim [NumRows];

        always #2 Data_Rdy = ~Data_Rdy;  // 4 ns period

        uartRxTop u_dut (.*);

        uartRxChecker chk (
                .Data_Rdy (Data_Rdy), .Pop_Data (Pop_Data), .bistMode (bistMode),
                .popReq (popReq), .strobe (u_dut.byteBus.strobe),
                .dataOut (dataOut), .dataStatus (dataStatus), .fifoEmpty (fifoEmpty),
                .fifoHalf (fifoHalf), .fifoFull (fifoFull), .fifoOverflow (fifoOverflow)
        );

        task automatic nextCycles(int n);
                repeat (n) @(posedge Data_Rdy);
                #0.5;                    // Drive just after the edge
        endtask

        task automatic driveBit(logic b);
                rxLine = b;
                nextCycles(`CLKS_PER_BIT);
        endtask

        // 8 data bits LSB first then optional even parity and one stop bit
        task automatic sendFrame(logic [7:0] d, bit badPar, bit badStop);
                driveBit(1'b0);
                for (int i = 0; i < 8; i++)
                        driveBit(d[i]);
                if (`PARITY_EN != 0)
                        driveBit(^d ^ badPar);
                driveBit(!badStop);
                rxLine = 1'b1;
        endtask

        task automatic waitReceived();
                int n;
                for (n = 0; n < 400 && chk.pending() != 0; n++)
                        nextCycles(1);
                if (chk.pending() != 0)
                        chk.noteTimeout("a character to reach the FIFO");
        endtask

        task automatic sendChar(logic [7:0] d, bit badPar, bit badStop);
                chk.noteSent('{status: '{frameErr: badStop, parityErr: badPar}, data: d});
                sendFrame(d, badPar, badStop);
                waitReceived();
                nextCycles($urandom_range(1, 8));   // Idle gap
        endtask

        task automatic popTimes(int n);
                repeat (n) begin
                        popReq = 1'b1;
                        nextCycles(1);
                        popReq = 1'b0;
                        nextCycles(1);
                end
        endtask

        // Count BIST strobes at the character bus
        task automatic waitBistStrobes(int want);
                int seen;
                int n;
                seen = 0;
                for (n = 0; n < 5000 && seen < want; n++) begin
                        nextCycles(1);
                        if (u_dut.byteBus.strobe)
                                seen++;
                end
                if (seen < want)
                        chk.noteTimeout("BIST characters to come back");
        endtask

        initial begin : mainSeq
                int n;
                void'($urandom(35177));
                stim[0] = '{8'h3C, 0, 0, 0};
                stim[1] = '{8'hA7, 0, 0, 0};
                stim[2] = '{8'h01, 0, 0, 2};
                stim[3] = '{8'h5A, 1, 0, 2};     // Parity error
                stim[4] = '{8'hC3, 0, 1, 2};     // Framing error then an empty pop
                for (int i = 0; i < 17; i++)     // Fill past full
                        stim[5 + i] = '{8'h80 + 8'(i * 3), 0, 0, (i == 16) ? 17 : 0};

                nextCycles(2);
                Pop_Data = 1'b0;
                nextCycles(2);
                chk.compareHex("bistBusy", 32'(bistBusy), 32'h0);   // Reset state
                chk.compareHex("bistDone", 32'(bistDone), 32'h0);
                chk.compareHex("bistPass", 32'(bistPass), 32'h0);

                foreach (stim[i]) begin
                        sendChar(stim[i].data, stim[i].badPar, stim[i].badStop);
                        popTimes(stim[i].pops);
                end

                ////////////////////
                // Full BIST run with the FIFO frozen
                sendChar(8'h11, 0, 0);
                sendChar(8'h22, 0, 0);
                bistMode = 1'b1;
                nextCycles(1);
                chk.compareHex("bistBusy", 32'(bistBusy), 32'h1);
                sendFrame(8'hEE, 0, 0);          // Must not reach the FIFO
                popTimes(2);
                for (n = 0; n < 8000 && !bistDone; n++)
                        nextCycles(1);
                if (!bistDone)
                        chk.noteTimeout("bistDone");
                chk.compareHex("bistBusy", 32'(bistBusy), 32'h0);
                chk.compareHex("bistPass", 32'(bistPass), 32'h1);
                bistMode = 1'b0;
                nextCycles(2);
                chk.compareHex("bistDone", 32'(bistDone), 32'h0);
                chk.compareHex("bistPass", 32'(bistPass), 32'h0);   // Released with the mode
                popTimes(2);

                ////////////////////
                // Abort mid-run just after a returned character
                bistMode = 1'b1;
                waitBistStrobes(4);
                nextCycles(1);
                bistMode = 1'b0;
                nextCycles(2);
                chk.compareHex("bistBusy", 32'(bistBusy), 32'h0);
                chk.compareHex("bistDone", 32'(bistDone), 32'h0);
                sendChar(8'h6E, 0, 0);
                popTimes(1);
                nextCycles(4);

                chk.report();
                if (chk.errCount == 0 && chk.timeoutCount == 0)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule

//--- uartRx_cfg.svh
// Build-time configuration of the serial receiver
// Character format, FIFO size, bit timing and self-test length
`ifndef UART_RX_CFG_SVH
`define UART_RX_CFG_SVH

////////////////////
// Character format
`define DATA_BITS     8      // Character width
`define PARITY_EN     1      // Even parity bit after the data

////////////////////
// Buffer and timing
`define FIFO_WIDTH    4      // Address bits, 16 entries
`define CLKS_PER_BIT  16     // Data_Rdy cycles per serial bit

// Self-test
`define BIST_BYTES    16     // Characters per run
`define BIST_SEED     8'hA5  // LFSR start, never zero

`endif
